// File: icache_pkg.sv
package icache_pkg;

  // ============================================================
  // cache geometry
  // ============================================================
  localparam int ADDR_W         = 32;
  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_W       = 4;
  localparam int INDEX_W        = 4;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_W         = 128;
  localparam int WAY_IDX_W      = 1;

  // derived widths
  localparam int WORD_W         = LINE_W / WORDS_PER_LINE;
  localparam int WOFF_W         = $clog2(WORDS_PER_LINE);
  localparam int BYTE_W         = OFFSET_W - WOFF_W;

  // ============================================================
  // pipeline and bus structs
  // ============================================================
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic               valid;
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WOFF_W-1:0]  woff;
  } dec_req_t;

  // lookup result, request fields travel along
  typedef struct packed {
    logic                 valid;
    logic                 hit;
    logic [WORD_W-1:0]    word;
    logic [WAY_IDX_W-1:0] victim;
    logic [TAG_W-1:0]     tag;
    logic [INDEX_W-1:0]   index;
    logic [WOFF_W-1:0]    woff;
  } lookup_res_t;

  typedef struct packed {
    logic                 en;
    logic [WAY_IDX_W-1:0] way;
    logic [INDEX_W-1:0]   index;
    logic [TAG_W-1:0]     tag;
    logic [LINE_W-1:0]    line;
  } line_wr_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
    logic              last;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQ,
    RF_FILL,
    RF_RESP
  } refill_state_e;

endpackage

// File: icache_addr_decode.sv
`timescale 1ns/1ps

module icache_addr_decode (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  icache_pkg::fetch_req_t         fetch_i,
  output icache_pkg::dec_req_t           dec_o,
  output logic [icache_pkg::INDEX_W-1:0] index_o
);
  import icache_pkg::*;

  logic               valid_q;
  logic [TAG_W-1:0]   tag_q;
  logic [INDEX_W-1:0] index_q;
  logic [WOFF_W-1:0]  woff_q;

  // raw index feeds the way RAMs so they read at the capture edge
  assign index_o = fetch_i.addr[OFFSET_W +: INDEX_W];

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_i.valid) begin
      tag_q   <= fetch_i.addr[ADDR_W-1 -: TAG_W];
      index_q <= fetch_i.addr[OFFSET_W +: INDEX_W];
      woff_q  <= fetch_i.addr[BYTE_W +: WOFF_W];
    end
  end

  assign dec_o = '{valid: valid_q, tag: tag_q, index: index_q, woff: woff_q};

  // instructions are word aligned
  a_fetch_aligned: assert property (@(posedge clk) disable iff (!s_rst_n)
    fetch_i.valid |-> fetch_i.addr[BYTE_W-1:0] == '0);

endmodule

// File: icache_way_ram.sv
`timescale 1ns/1ps

module icache_way_ram (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  logic [icache_pkg::INDEX_W-1:0] rd_index_i,
  input  logic                           wr_en_i,
  input  logic [icache_pkg::INDEX_W-1:0] wr_index_i,
  input  logic [icache_pkg::TAG_W-1:0]   wr_tag_i,
  input  logic [icache_pkg::LINE_W-1:0]  wr_line_i,
  input  logic                           clear_i,
  output logic                           valid_o,
  output logic [icache_pkg::TAG_W-1:0]   tag_o,
  output logic [icache_pkg::LINE_W-1:0]  line_o
);
  import icache_pkg::*;

  logic [SETS-1:0]  valid_q;
  logic [TAG_W-1:0] tag_mem  [SETS];
  logic [LINE_W-1:0] line_mem [SETS];
  logic             wr_hit_rd;

  assign wr_hit_rd = wr_en_i && (wr_index_i == rd_index_i);

  // valid bits, flush clears all of them at once
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      valid_q <= '0;
      valid_o <= 1'b0;
    end else if (clear_i) begin
      valid_q <= '0;
      valid_o <= 1'b0;
    end else begin
      if (wr_en_i) begin
        valid_q[wr_index_i] <= 1'b1;
      end
      valid_o <= wr_hit_rd ? 1'b1 : valid_q[rd_index_i];
    end
  end

  // tag and line storage, write first on same index
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i]  <= wr_tag_i;
      line_mem[wr_index_i] <= wr_line_i;
    end
    tag_o  <= wr_hit_rd ? wr_tag_i  : tag_mem[rd_index_i];
    line_o <= wr_hit_rd ? wr_line_i : line_mem[rd_index_i];
  end

endmodule

// File: icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  logic [icache_pkg::INDEX_W-1:0] rd_index_i,
  input  icache_pkg::dec_req_t           dec_i,
  input  icache_pkg::line_wr_t           line_wr_i,
  input  logic                           flush_i,
  output icache_pkg::lookup_res_t        res_o
);
  import icache_pkg::*;

  logic [WAYS-1:0]                       way_valid;
  logic [WAYS-1:0][TAG_W-1:0]            way_tag;
  logic [WAYS-1:0][LINE_W-1:0]           way_line;
  logic [WAYS-1:0]                       way_hit;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] hit_line;
  logic [WAY_IDX_W-1:0]                  victim_q [SETS];

  // ============================================================
  // way storage and tag compare
  // ============================================================
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    icache_way_ram icache_way_ram_inst (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .rd_index_i (rd_index_i),
      .wr_en_i    (line_wr_i.en && (line_wr_i.way == WAY_IDX_W'(w))),
      .wr_index_i (line_wr_i.index),
      .wr_tag_i   (line_wr_i.tag),
      .wr_line_i  (line_wr_i.line),
      .clear_i    (flush_i),
      .valid_o    (way_valid[w]),
      .tag_o      (way_tag[w]),
      .line_o     (way_line[w])
    );

    assign way_hit[w] = way_valid[w] && (way_tag[w] == dec_i.tag);
  end

  // at most one way hits, so an OR of the masked lines is the select
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (way_hit[w]) begin
        hit_line = hit_line | way_line[w];
      end
    end
  end

  always_comb begin
    res_o.valid  = dec_i.valid;
    res_o.hit    = dec_i.valid && (|way_hit);
    res_o.word   = hit_line[dec_i.woff];
    res_o.victim = victim_q[dec_i.index];
    res_o.tag    = dec_i.tag;
    res_o.index  = dec_i.index;
    res_o.woff   = dec_i.woff;
  end

  // ============================================================
  // round-robin victim pointer per set
  // ============================================================
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        victim_q[s] <= '0;
      end
    end else if (flush_i) begin
      for (int s = 0; s < SETS; s++) begin
        victim_q[s] <= '0;
      end
    end else if (line_wr_i.en) begin
      victim_q[line_wr_i.index] <= victim_q[line_wr_i.index] + 1'b1;
    end
  end

  // a line is only ever filled into the victim way after a miss
  a_single_hit: assert property (@(posedge clk) disable iff (!s_rst_n)
    dec_i.valid |-> $onehot0(way_hit));

endmodule

// File: icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  icache_pkg::lookup_res_t res_i,
  input  logic                    mem_ready_i,
  input  icache_pkg::mem_rsp_t    mem_rsp_i,
  output icache_pkg::line_wr_t    line_wr_o,
  output icache_pkg::mem_req_t    mem_req_o,
  output icache_pkg::fetch_rsp_t  fetch_rsp_o,
  output logic                    busy_o
);
  import icache_pkg::*;

  refill_state_e                         state_q;
  refill_state_e                         state_d;
  logic [WOFF_W-1:0]                     beat_cnt_q;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_buf_q;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_asm;

  // latched miss request
  logic [TAG_W-1:0]     miss_tag_q;
  logic [INDEX_W-1:0]   miss_index_q;
  logic [WOFF_W-1:0]    miss_woff_q;
  logic [WAY_IDX_W-1:0] miss_way_q;

  logic              miss;
  logic              beat_in;
  logic              last_beat;
  logic              rsp_valid_q;
  logic              rsp_hit_q;
  logic [ADDR_W-1:0] rsp_addr_q;
  logic [WORD_W-1:0] rsp_instr_q;

  assign miss      = res_i.valid && !res_i.hit;
  assign beat_in   = (state_q == RF_FILL) && mem_rsp_i.valid;
  assign last_beat = beat_in && mem_rsp_i.last;

  // ============================================================
  // refill FSM
  // ============================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: if (miss)        state_d = RF_REQ;
      RF_REQ:  if (mem_ready_i) state_d = RF_FILL;
      RF_FILL: if (last_beat)   state_d = RF_RESP;
      RF_RESP:                  state_d = RF_IDLE;
      default:                  state_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      state_q    <= RF_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RF_REQ) begin
        beat_cnt_q <= '0;
      end else if (beat_in) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE && miss) begin
      miss_tag_q   <= res_i.tag;
      miss_index_q <= res_i.index;
      miss_woff_q  <= res_i.woff;
      miss_way_q   <= res_i.victim;
    end
    if (beat_in) begin
      line_buf_q[beat_cnt_q] <= mem_rsp_i.data;
    end
  end

  // line with the incoming beat merged in, used on the last beat
  always_comb begin
    line_asm = line_buf_q;
    if (beat_in) begin
      line_asm[beat_cnt_q] = mem_rsp_i.data;
    end
  end

  assign line_wr_o = '{en: last_beat, way: miss_way_q, index: miss_index_q,
                       tag: miss_tag_q, line: line_asm};

  assign mem_req_o = '{valid: state_q == RF_REQ,
                       addr: {miss_tag_q, miss_index_q, OFFSET_W'(0)}};

  // ============================================================
  // response register
  // ============================================================
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= (res_i.valid && res_i.hit) || last_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (res_i.valid && res_i.hit) begin
      rsp_hit_q   <= 1'b1;
      rsp_addr_q  <= {res_i.tag, res_i.index, res_i.woff, BYTE_W'(0)};
      rsp_instr_q <= res_i.word;
    end else if (last_beat) begin
      rsp_hit_q   <= 1'b0;
      rsp_addr_q  <= {miss_tag_q, miss_index_q, miss_woff_q, BYTE_W'(0)};
      rsp_instr_q <= line_asm[miss_woff_q];
    end
  end

  assign fetch_rsp_o = '{valid: rsp_valid_q, hit: rsp_hit_q,
                         addr: rsp_addr_q, instr: rsp_instr_q};

  // RF_RESP is the response cycle and already accepts the next fetch
  assign busy_o = miss || (state_q == RF_REQ) || (state_q == RF_FILL);

  a_beat_only_in_fill: assert property (@(posedge clk) disable iff (!s_rst_n)
    mem_rsp_i.valid |-> state_q == RF_FILL);

  a_last_on_fourth: assert property (@(posedge clk) disable iff (!s_rst_n)
    beat_in |-> mem_rsp_i.last == (beat_cnt_q == WOFF_W'(WORDS_PER_LINE - 1)));

endmodule

// File: icache_top.sv
`timescale 1ns/1ps

module icache_top (
  input  logic                   clk,
  input  logic                   s_rst_n,
  input  icache_pkg::fetch_req_t fetch_i,
  input  logic                   flush_i,
  input  logic                   mem_ready_i,
  input  icache_pkg::mem_rsp_t   mem_rsp_i,
  output logic                   busy_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  output icache_pkg::mem_req_t   mem_req_o
);
  import icache_pkg::*;

  dec_req_t           dec;
  logic [INDEX_W-1:0] rd_index;
  lookup_res_t        res;
  line_wr_t           line_wr;
  logic               flush_ok;

  // flush is ignored during a refill
  assign flush_ok = flush_i && !busy_o;

  icache_addr_decode icache_addr_decode_inst (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .fetch_i (fetch_i),
    .dec_o   (dec),
    .index_o (rd_index)
  );

  icache_lookup icache_lookup_inst (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .rd_index_i (rd_index),
    .dec_i      (dec),
    .line_wr_i  (line_wr),
    .flush_i    (flush_ok),
    .res_o      (res)
  );

  icache_refill icache_refill_inst (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .res_i       (res),
    .mem_ready_i (mem_ready_i),
    .mem_rsp_i   (mem_rsp_i),
    .line_wr_o   (line_wr),
    .mem_req_o   (mem_req_o),
    .fetch_rsp_o (fetch_rsp_o),
    .busy_o      (busy_o)
  );

  // environment holds off while a miss is pending
  a_no_fetch_when_busy: assert property (@(posedge clk) disable iff (!s_rst_n)
    fetch_i.valid |-> !busy_o);

endmodule

// File: icache_tb_clk.sv
`timescale 1ns/1ps

module icache_tb_clk #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end
endmodule

// File: icache_tb_mem.sv
`timescale 1ns/1ps

module icache_tb_mem #(
  parameter logic [31:0] PATTERN = 32'h5A5A_0000,
  parameter logic [15:0] SEED    = 16'd50
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  icache_pkg::mem_req_t mem_req_i,
  output logic                 mem_ready_o,
  output icache_pkg::mem_rsp_t mem_rsp_o
);
  import icache_pkg::*;

  logic [15:0]       lfsr_q;
  logic [ADDR_W-1:0] line_addr;

  // two LFSR bits, delay of 0 to 3 cycles
  function automatic int delay_cycles();
    int d;
    d = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      d = 2 * d + lfsr_q[0];
    end
    return d;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    lfsr_q      = SEED;
    mem_ready_o = 1'b0;
    mem_rsp_o   = '0;
    forever begin
      idle_cycles(1);
      if (s_rst_n && mem_req_i.valid) begin
        line_addr = mem_req_i.addr;
        idle_cycles(delay_cycles());
        mem_ready_o = 1'b1;
        idle_cycles(1);
        mem_ready_o = 1'b0;
        // beats in increasing address order
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
          idle_cycles(delay_cycles());
          mem_rsp_o = '{valid: 1'b1, data: (line_addr + 4 * b) ^ PATTERN,
                        last: b == WORDS_PER_LINE - 1};
          idle_cycles(1);
          mem_rsp_o = '0;
        end
      end
    end
  end
endmodule

// File: icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam logic [31:0] PATTERN    = 32'h5A5A_0000;
  localparam logic [15:0] SEED       = 16'd50;
  localparam logic [31:0] RAND_BASE  = 32'h0004_0000;
  localparam int          N_RANDOM   = 200;
  localparam int          DRAIN_MAX  = 64;
  // random test dominates, a slow refill stays under 20 cycles on average
  localparam int          MAX_CYCLES = 20 * N_RANDOM;

  typedef struct packed {
    fetch_rsp_t rsp;
    int         cyc;
  } exp_rsp_t;

  logic             clk;
  logic             s_rst_n;
  logic             flush;
  logic             mem_ready;
  logic             busy;
  fetch_req_t       fetch_req;
  fetch_rsp_t       rsp;
  mem_req_t         mem_req;
  mem_rsp_t         mem_rsp;
  exp_rsp_t         exp_q [$];
  exp_rsp_t         head;
  mem_req_t         exp_req_q [$];
  logic [TAG_W-1:0] ref_tag [SETS][WAYS];
  logic             ref_valid [SETS][WAYS];
  int               ref_victim [SETS];
  refill_state_e    rf_state;
  logic [15:0]      lfsr_q;
  int               cycle = 0;
  int               errors = 0;
  int               checks = 0;

  icache_tb_clk #(.PERIOD_NS(20)) icache_tb_clk_inst (.clk_o(clk));

  icache_top icache_top_inst (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .fetch_i     (fetch_req),
    .flush_i     (flush),
    .mem_ready_i (mem_ready),
    .mem_rsp_i   (mem_rsp),
    .busy_o      (busy),
    .fetch_rsp_o (rsp),
    .mem_req_o   (mem_req)
  );

  icache_tb_mem #(.PATTERN(PATTERN), .SEED(SEED)) icache_tb_mem_inst (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .mem_req_i   (mem_req),
    .mem_ready_o (mem_ready),
    .mem_rsp_o   (mem_rsp)
  );

  // ============================================================
  // reference model and helpers
  // ============================================================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic void ref_clear();
    for (int s = 0; s < SETS; s++) begin
      ref_victim[s] = 0;
      for (int w = 0; w < WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
      end
    end
  endfunction

  // two ways per set, round-robin replacement on a miss
  function automatic logic ref_access(input logic [ADDR_W-1:0] addr);
    logic [TAG_W-1:0] tag;
    int               idx;
    logic             hit;
    tag = addr[ADDR_W-1 -: TAG_W];
    idx = addr[OFFSET_W +: INDEX_W];
    hit = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      hit = hit | (ref_valid[idx][w] && ref_tag[idx][w] == tag);
    end
    if (!hit) begin
      ref_valid[idx][ref_victim[idx]] = 1'b1;
      ref_tag[idx][ref_victim[idx]]   = tag;
      ref_victim[idx] = (ref_victim[idx] + 1) % WAYS;
    end
    return hit;
  endfunction

  task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
    checks++;
    if (got.hit !== exp.hit || got.addr !== exp.addr || got.instr !== exp.instr) begin
      $display("[FAIL] %0t: rsp addr %h hit %b instr %h, expected addr %h hit %b instr %h",
               $time, got.addr, got.hit, got.instr, exp.addr, exp.hit, exp.instr);
      errors++;
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
    checks++;
    if (got.addr !== exp.addr) begin
      $display("[FAIL] %0t: memory request addr %h, expected %h", $time, got.addr, exp.addr);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic issue_fetch(input logic [ADDR_W-1:0] addr);
    logic hit;
    while (busy) begin
      next_cycle();
    end
    hit = ref_access(addr);
    exp_q.push_back('{rsp: '{valid: 1'b1, hit: hit, addr: addr, instr: addr ^ PATTERN},
                      cyc: cycle});
    if (!hit) begin
      exp_req_q.push_back('{valid: 1'b1, addr: {addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)}});
    end
    fetch_req = '{valid: 1'b1, addr: addr};
    next_cycle();
    fetch_req.valid = 1'b0;
  endtask

  task automatic flush_cache();
    while (busy) begin
      next_cycle();
    end
    flush = 1'b1;
    ref_clear();
    next_cycle();
    flush = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || busy) && waited < DRAIN_MAX) begin
      next_cycle();
      waited++;
    end
    if (exp_q.size() != 0 || exp_req_q.size() != 0) begin
      $display("%0t: %0d responses and %0d memory requests never arrived",
               $time, exp_q.size(), exp_req_q.size());
      errors++;
      exp_q.delete();
      exp_req_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %-18s %s, %0d errors", name, errors == err0 ? "ok" : "failed",
             errors - err0);
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic test_reset_miss();
    int err0;
    err0 = errors;
    checks++;
    if (busy !== 1'b0 || rsp.valid !== 1'b0 || mem_req.valid !== 1'b0) begin
      $display("[FAIL] %0t: after reset busy %b rsp valid %b mem req valid %b",
               $time, busy, rsp.valid, mem_req.valid);
      errors++;
    end
    issue_fetch(32'h0000_1004);
    wait_drain();
    report_test("reset_first_miss", err0);
  endtask

  task automatic test_line_hits();
    int err0;
    int c0;
    err0 = errors;
    c0   = cycle;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      issue_fetch(32'h0000_1000 + 4 * i);
    end
    if (cycle - c0 != WORDS_PER_LINE) begin
      $display("%0t: line hits were not accepted in consecutive cycles", $time);
      errors++;
    end
    wait_drain();
    report_test("line_hits", err0);
  endtask

  task automatic test_round_robin();
    int err0;
    err0 = errors;
    // A, B, C all map to set 5
    issue_fetch(32'h0001_0050);
    issue_fetch(32'h0002_0054);
    issue_fetch(32'h0003_0058);
    issue_fetch(32'h0001_005C);
    wait_drain();
    report_test("round_robin", err0);
  endtask

  task automatic test_flush();
    int err0;
    err0 = errors;
    issue_fetch(32'h0000_1008);
    wait_drain();
    flush_cache();
    issue_fetch(32'h0000_1008);
    wait_drain();
    report_test("flush", err0);
  endtask

  task automatic test_random();
    int err0;
    err0 = errors;
    // 512 words, a 2 KB window
    for (int i = 0; i < N_RANDOM; i++) begin
      issue_fetch(RAND_BASE + (rand_bits(9) << 2));
    end
    wait_drain();
    report_test("random", err0);
  endtask

  // ============================================================
  // monitors, timeout and sequence
  // ============================================================
  always @(negedge clk) begin
    if (s_rst_n && rsp.valid) begin
      if (exp_q.size() == 0) begin
        $display("%0t: response for %h with no request outstanding", $time, rsp.addr);
        errors++;
      end else begin
        head = exp_q.pop_front();
        if (head.rsp.hit && cycle - head.cyc != 2) begin
          $display("[FAIL] %0t: hit latency %0d cycles, expected 2", $time, cycle - head.cyc);
          errors++;
        end
        check_rsp(rsp, head.rsp);
      end
    end
    if (s_rst_n && mem_req.valid && mem_ready) begin
      if (exp_req_q.size() == 0) begin
        $display("%0t: memory request to %h without a miss", $time, mem_req.addr);
        errors++;
      end else begin
        check_mem_req(mem_req, exp_req_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle == MAX_CYCLES) begin
      rf_state = icache_top_inst.icache_refill_inst.state_q;
      $display("run stopped after %0d cycles, refill state %s", cycle, rf_state.name());
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    s_rst_n   = 1'b0;
    fetch_req = '0;
    flush     = 1'b0;
    lfsr_q    = SEED;
    ref_clear();
    repeat (5) @(posedge clk);
    #2;
    s_rst_n = 1'b1;
    next_cycle();
    test_reset_miss();
    test_line_hits();
    test_round_robin();
    test_flush();
    test_random();
    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: icache.f
icache_pkg.sv
icache_addr_decode.sv
icache_way_ram.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
icache_tb_clk.sv
icache_tb_mem.sv
icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_addr_decode.sv
  - icache_way_ram.sv
  - icache_lookup.sv
  - icache_refill.sv
  - icache_top.sv
  - target: test
    files:
      - icache_tb_clk.sv
      - icache_tb_mem.sv
      - icache_tb.sv
